// ==== include/ex_defs.svh ====
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// datapath and pc width
`define XLEN 64

// register index width, x0..x31
`define REG_ADDR_W 5

// sequential fetch step, no compressed instructions
`define PC_STEP 4

// shift amounts for doubleword and word forms
`define SHAMT_W 6
`define WORD_SHAMT_W 5

`endif

// ==== verilog/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    // instruction class as decoded by ID
    // numeric values are what the stimulus file carries
    typedef enum logic [3:0] {
        CLS_NONE     = 4'd0,
        CLS_LUI      = 4'd1,
        CLS_AUIPC    = 4'd2,
        CLS_JAL      = 4'd3,
        CLS_JALR     = 4'd4,
        CLS_BRANCH   = 4'd5,
        CLS_LOAD     = 4'd6,
        CLS_STORE    = 4'd7,
        CLS_OP_IMM   = 4'd8,
        CLS_OP       = 4'd9,
        CLS_OP_IMM_W = 4'd10,
        CLS_OP_W     = 4'd11
    } op_class_e;

    // alu operation, decoded inside the ALU from class/funct3/alt
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_e;

endpackage

`default_nettype wire

// ==== verilog/ex_issue_reg.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "ex_defs.svh"

module ex_issue_reg (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    out_ready,
    input  logic                    in_valid,
    input  logic [`XLEN-1:0]        in_pc,
    input  ex_pkg::op_class_e       in_class,
    input  logic [2:0]              in_funct3,
    input  logic                    in_alt,
    input  logic [`REG_ADDR_W-1:0]  in_rd,
    input  logic [`REG_ADDR_W-1:0]  in_rs1,
    input  logic [`REG_ADDR_W-1:0]  in_rs2,
    input  logic [`XLEN-1:0]        in_src_a,
    input  logic [`XLEN-1:0]        in_src_b,
    input  logic [`XLEN-1:0]        in_imm,
    output logic                    in_ready,
    output logic                    ex_valid,
    output logic [`XLEN-1:0]        ex_pc,
    output ex_pkg::op_class_e       ex_class,
    output logic [2:0]              ex_funct3,
    output logic                    ex_alt,
    output logic [`REG_ADDR_W-1:0]  ex_rd,
    output logic [`REG_ADDR_W-1:0]  ex_rs1,
    output logic [`REG_ADDR_W-1:0]  ex_rs2,
    output logic [`XLEN-1:0]        ex_src_a,
    output logic [`XLEN-1:0]        ex_src_b,
    output logic [`XLEN-1:0]        ex_imm
);
    import ex_pkg::*;

    // nothing in this stage stalls on its own
    // so the slot frees exactly when MEM takes the item
    assign in_ready = out_ready;

    // valid and class, cleared by reset or branch flush
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ex_valid <= 1'b0;
            ex_class <= CLS_NONE;
        end else if (in_ready) begin
            ex_valid <= in_valid;
            ex_class <= in_class;
        end
    end

    // payload fields, loaded together with valid
    // held unchanged while MEM back-pressures
    always_ff @(posedge clk) begin
        if (in_ready) begin
            ex_pc     <= in_pc;
            ex_funct3 <= in_funct3;
            ex_alt    <= in_alt;
            ex_rd     <= in_rd;
            ex_rs1    <= in_rs1;
            ex_rs2    <= in_rs2;
            ex_src_a  <= in_src_a;
            ex_src_b  <= in_src_b;
            ex_imm    <= in_imm;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ex_operand_fwd.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "ex_defs.svh"

module ex_operand_fwd (
    input  ex_pkg::op_class_e       ex_class,
    input  logic [`REG_ADDR_W-1:0]  ex_rs1,
    input  logic [`REG_ADDR_W-1:0]  ex_rs2,
    input  logic [`XLEN-1:0]        ex_src_a,
    input  logic [`XLEN-1:0]        ex_src_b,
    input  logic                    mem_wr_en,
    input  logic [`REG_ADDR_W-1:0]  mem_rd,
    input  logic [`XLEN-1:0]        mem_data,
    input  logic                    wb_wr_en,
    input  logic [`REG_ADDR_W-1:0]  wb_rd,
    input  logic [`XLEN-1:0]        wb_data,
    output logic [`XLEN-1:0]        src1,
    output logic [`XLEN-1:0]        src2
);
    import ex_pkg::*;

    logic use_rs2;

    // bypass select for one source operand
    // MEM is younger than WB, so it wins on a double match
    function automatic logic [`XLEN-1:0] pick_source(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic                   allow,
        input logic [`XLEN-1:0]       reg_val
    );
        logic not_x0;
        logic mem_hit;
        logic wb_hit;
        // x0 reads as zero, never bypass it
        not_x0  = (rs != '0);
        mem_hit = allow && not_x0 && mem_wr_en && (mem_rd == rs);
        wb_hit  = allow && not_x0 && wb_wr_en && (wb_rd == rs);
        if (mem_hit) begin
            return mem_data;
        end else if (wb_hit) begin
            return wb_data;
        end
        return reg_val;
    endfunction

    // rs2 only meaningful for reg-reg ops, branches and stores
    // the rs2 field of an immediate form is part of the immediate
    assign use_rs2 = ex_class inside {CLS_BRANCH, CLS_STORE, CLS_OP, CLS_OP_W};

    always_comb begin
        src1 = pick_source(ex_rs1, 1'b1, ex_src_a);
        src2 = pick_source(ex_rs2, use_rs2, ex_src_b);
    end

endmodule

`default_nettype wire

// ==== verilog/ex_alu.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "ex_defs.svh"

module ex_alu (
    input  ex_pkg::op_class_e  ex_class,
    input  logic [2:0]         ex_funct3,
    input  logic               ex_alt,
    input  logic [`XLEN-1:0]   ex_pc,
    input  logic [`XLEN-1:0]   ex_imm,
    input  logic [`XLEN-1:0]   src1,
    input  logic [`XLEN-1:0]   src2,
    output logic [`XLEN-1:0]   result
);
    import ex_pkg::*;

    localparam int WORD_W = `XLEN / 2;

    alu_op_e              alu_op;
    logic                 is_word;
    logic                 is_reg_op;
    logic                 sign_fill;
    logic [`XLEN-1:0]     op_a;
    logic [`XLEN-1:0]     op_b;
    logic [`XLEN-1:0]     calc_a;
    logic [`SHAMT_W-1:0]  shamt;
    logic [`XLEN-1:0]     full_res;

    assign is_word   = ex_class inside {CLS_OP_IMM_W, CLS_OP_W};
    assign is_reg_op = ex_class inside {CLS_OP, CLS_OP_W};

    // funct3 decode for the arithmetic classes, everything else adds
    always_comb begin
        alu_op = ALU_ADD;
        if (ex_class inside {CLS_OP_IMM, CLS_OP, CLS_OP_IMM_W, CLS_OP_W}) begin
            case (ex_funct3)
                // addi has no subtract form, alt is an imm bit there
                3'b000:  alu_op = (ex_alt && is_reg_op) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = ex_alt ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    // operand a: zero for lui, pc for pc-relative and link
    always_comb begin
        case (ex_class)
            CLS_LUI:                      op_a = '0;
            CLS_AUIPC, CLS_JAL, CLS_JALR: op_a = ex_pc;
            default:                      op_a = src1;
        endcase
    end

    // operand b: link step, immediate, or rs2
    always_comb begin
        case (ex_class)
            CLS_JAL, CLS_JALR: op_b = `XLEN'(`PC_STEP);
            CLS_LUI, CLS_AUIPC, CLS_LOAD, CLS_STORE,
            CLS_OP_IMM, CLS_OP_IMM_W: op_b = ex_imm;
            default:                  op_b = src2;
        endcase
    end

    // word forms: low half only, upper bits prepared for right shifts
    // sra needs bit 31 copied up, srl needs zeros
    assign sign_fill = (alu_op == ALU_SRA) && op_a[WORD_W-1];
    assign calc_a    = is_word ? {{WORD_W{sign_fill}}, op_a[WORD_W-1:0]} : op_a;
    assign shamt     = is_word ? `SHAMT_W'(op_b[`WORD_SHAMT_W-1:0])
                               : op_b[`SHAMT_W-1:0];

    always_comb begin
        case (alu_op)
            ALU_SUB:  full_res = calc_a - op_b;
            ALU_SLT:  full_res = `XLEN'($signed(calc_a) < $signed(op_b));
            ALU_SLTU: full_res = `XLEN'(calc_a < op_b);
            ALU_AND:  full_res = calc_a & op_b;
            ALU_OR:   full_res = calc_a | op_b;
            ALU_XOR:  full_res = calc_a ^ op_b;
            ALU_SLL:  full_res = calc_a << shamt;
            ALU_SRL:  full_res = calc_a >> shamt;
            ALU_SRA:  full_res = $signed(calc_a) >>> shamt;
            default:  full_res = calc_a + op_b;
        endcase
    end

    // word results sign-extend from bit 31
    assign result = is_word ? {{WORD_W{full_res[WORD_W-1]}}, full_res[WORD_W-1:0]}
                            : full_res;

endmodule

`default_nettype wire

// ==== verilog/ex_branch_unit.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "ex_defs.svh"

module ex_branch_unit (
    input  logic               ex_valid,
    input  logic               out_ready,
    input  ex_pkg::op_class_e  ex_class,
    input  logic [2:0]         ex_funct3,
    input  logic [`XLEN-1:0]   ex_pc,
    input  logic [`XLEN-1:0]   ex_imm,
    input  logic [`XLEN-1:0]   src1,
    input  logic [`XLEN-1:0]   src2,
    output logic               pc_update,
    output logic [`XLEN-1:0]   dnpc
);
    import ex_pkg::*;

    logic              is_branch;
    logic              is_jalr;
    logic              taken;
    logic              predicted_taken;
    logic              mispredict;
    logic [`XLEN-1:0]  snpc;
    logic [`XLEN-1:0]  branch_target;
    logic [`XLEN-1:0]  jalr_sum;

    assign is_branch = (ex_class == CLS_BRANCH);
    assign is_jalr   = (ex_class == CLS_JALR);

    // branch condition on the forwarded operands
    always_comb begin
        case (ex_funct3)
            3'b000:  taken = (src1 == src2);
            3'b001:  taken = (src1 != src2);
            3'b100:  taken = ($signed(src1) < $signed(src2));
            3'b101:  taken = ($signed(src1) >= $signed(src2));
            3'b110:  taken = (src1 < src2);
            3'b111:  taken = (src1 >= src2);
            // 010/011 are not branches
            default: taken = 1'b0;
        endcase
    end

    // fetch already followed backward branches
    assign predicted_taken = ex_imm[`XLEN-1];
    assign mispredict      = is_branch && (taken != predicted_taken);

    assign snpc          = ex_pc + `XLEN'(`PC_STEP);
    assign branch_target = ex_pc + ex_imm;
    assign jalr_sum      = src1 + ex_imm;

    // redirect only when MEM takes the item this cycle
    assign pc_update = ex_valid && out_ready && (is_jalr || mispredict);

    // wrong "taken" guess falls through, wrong "not taken" jumps
    always_comb begin
        if (is_jalr) begin
            dnpc = {jalr_sum[`XLEN-1:1], 1'b0};
        end else if (predicted_taken) begin
            dnpc = snpc;
        end else begin
            dnpc = branch_target;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ex_unit.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "ex_defs.svh"

module ex_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [`XLEN-1:0]        in_pc,
    input  ex_pkg::op_class_e       in_class,
    input  logic [2:0]              in_funct3,
    input  logic                    in_alt,
    input  logic [`REG_ADDR_W-1:0]  in_rd,
    input  logic [`REG_ADDR_W-1:0]  in_rs1,
    input  logic [`REG_ADDR_W-1:0]  in_rs2,
    input  logic [`XLEN-1:0]        in_src_a,
    input  logic [`XLEN-1:0]        in_src_b,
    input  logic [`XLEN-1:0]        in_imm,
    input  logic                    mem_wr_en,
    input  logic [`REG_ADDR_W-1:0]  mem_rd,
    input  logic [`XLEN-1:0]        mem_data,
    input  logic                    wb_wr_en,
    input  logic [`REG_ADDR_W-1:0]  wb_rd,
    input  logic [`XLEN-1:0]        wb_data,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [`XLEN-1:0]        out_pc,
    output ex_pkg::op_class_e       out_class,
    output logic [`REG_ADDR_W-1:0]  out_rd,
    output logic [`XLEN-1:0]        out_result,
    output logic [`XLEN-1:0]        out_store_data,
    output logic                    pc_update,
    output logic [`XLEN-1:0]        dnpc
);
    import ex_pkg::*;

    logic                    ex_valid;
    logic [`XLEN-1:0]        ex_pc;
    op_class_e               ex_class;
    logic [2:0]              ex_funct3;
    logic                    ex_alt;
    logic [`REG_ADDR_W-1:0]  ex_rs1;
    logic [`REG_ADDR_W-1:0]  ex_rs2;
    logic [`XLEN-1:0]        ex_src_a;
    logic [`XLEN-1:0]        ex_src_b;
    logic [`XLEN-1:0]        ex_imm;
    logic [`XLEN-1:0]        src1;
    logic [`XLEN-1:0]        src2;

    // ID/EX register, the only state in the stage
    ex_issue_reg ex_issue_reg_i (
        .clk(clk), .reset(reset), .flush(flush), .out_ready(out_ready),
        .in_valid(in_valid), .in_pc(in_pc), .in_class(in_class),
        .in_funct3(in_funct3), .in_alt(in_alt), .in_rd(in_rd),
        .in_rs1(in_rs1), .in_rs2(in_rs2), .in_src_a(in_src_a),
        .in_src_b(in_src_b), .in_imm(in_imm), .in_ready(in_ready),
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_class(ex_class),
        .ex_funct3(ex_funct3), .ex_alt(ex_alt), .ex_rd(out_rd),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_src_a(ex_src_a),
        .ex_src_b(ex_src_b), .ex_imm(ex_imm)
    );

    // bypass from MEM/WB against the held item
    ex_operand_fwd ex_operand_fwd_i (
        .ex_class(ex_class), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
        .ex_src_a(ex_src_a), .ex_src_b(ex_src_b),
        .mem_wr_en(mem_wr_en), .mem_rd(mem_rd), .mem_data(mem_data),
        .wb_wr_en(wb_wr_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .src1(src1), .src2(src2)
    );

    ex_alu ex_alu_i (
        .ex_class(ex_class), .ex_funct3(ex_funct3), .ex_alt(ex_alt),
        .ex_pc(ex_pc), .ex_imm(ex_imm), .src1(src1), .src2(src2),
        .result(out_result)
    );

    // redirect toward fetch
    ex_branch_unit ex_branch_unit_i (
        .ex_valid(ex_valid), .out_ready(out_ready), .ex_class(ex_class),
        .ex_funct3(ex_funct3), .ex_pc(ex_pc), .ex_imm(ex_imm),
        .src1(src1), .src2(src2), .pc_update(pc_update), .dnpc(dnpc)
    );

    assign out_valid      = ex_valid;
    assign out_pc         = ex_pc;
    assign out_class      = ex_class;
    // store data is the bypassed rs2
    assign out_store_data = src2;

    // anything handed to MEM carries a real instruction class
    a_valid_has_class: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> ex_class != CLS_NONE);

    // a held branch carries one of the six branch encodings
    a_branch_funct3: assert property (@(posedge clk) disable iff (reset)
        out_valid && ex_class == CLS_BRANCH |-> !(ex_funct3 inside {3'b010, 3'b011}));

endmodule

`default_nettype wire

// ==== tests/ex_unit_checker.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "ex_defs.svh"

module ex_unit_checker (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    out_valid,
    input  logic                    out_ready,
    input  logic                    pc_update,
    input  logic [`XLEN-1:0]        out_pc,
    input  ex_pkg::op_class_e       out_class,
    input  logic [`REG_ADDR_W-1:0]  out_rd,
    input  logic [`XLEN-1:0]        out_result,
    input  logic [`XLEN-1:0]        out_store_data,
    input  logic [`XLEN-1:0]        dnpc,
    output int                      error_count,
    output int                      pending
);
    int          errors = 0;
    int          exp_line[$];
    logic [63:0] exp_pc[$];
    logic [63:0] exp_class[$];
    logic [63:0] exp_result[$];
    logic [63:0] exp_store[$];
    logic [63:0] exp_pcu[$];
    logic [63:0] exp_dnpc[$];

    assign error_count = errors;
    assign pending     = exp_line.size();

    // expected items in order, flushed lines never reach MEM
    initial begin
        int          fd;
        int          line_no;
        string       text;
        logic [63:0] v[0:19];
        line_no = 0;
        fd = $fopen("tests/ex_stimulus.txt", "r");
        while (fd != 0 && !$feof(fd)) begin
            line_no++;
            if ($fgets(text, fd) > 0 && $sscanf(text,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18],
                v[19]) == 20 && !v[3][0]) begin
                exp_line.push_back(line_no);
                exp_pc.push_back(v[4]);
                exp_class.push_back(v[0]);
                exp_result.push_back(v[16]);
                exp_store.push_back(v[17]);
                exp_pcu.push_back(v[18]);
                exp_dnpc.push_back(v[19]);
            end
        end
    end

    task automatic check_value(input string field, input int line_no,
                               input logic [63:0] expv, input logic [63:0] actv);
        if (actv !== expv) begin
            errors++;
            $display("** Error line %0d %s: expected %h, actual %h",
                     line_no, field, expv, actv);
        end
    endtask

    // values are read just after the edge, i.e. as the DUT held them
    always @(posedge clk) begin
        if (!reset && pc_update && !out_ready) begin
            errors++;
            $display("pc_update was high while out_ready was low");
        end
        if (!reset && out_valid && out_ready && !flush) begin
            if (exp_line.size() == 0) begin
                errors++;
                $display("output transfer seen with no item left to expect");
            end else begin
                check_value("out_pc", exp_line[0], exp_pc[0], out_pc);
                check_value("out_class", exp_line[0], exp_class[0], 64'(out_class));
                // rd carries the low bits of the line number
                check_value("out_rd", exp_line[0], 64'(exp_line[0] % 32), 64'(out_rd));
                check_value("out_result", exp_line[0], exp_result[0], out_result);
                check_value("out_store_data", exp_line[0], exp_store[0], out_store_data);
                check_value("pc_update", exp_line[0], exp_pcu[0], 64'(pc_update));
                // target only means something on a redirect
                if (exp_pcu[0][0]) begin
                    check_value("dnpc", exp_line[0], exp_dnpc[0], dnpc);
                end
                void'(exp_line.pop_front());
                void'(exp_pc.pop_front());
                void'(exp_class.pop_front());
                void'(exp_result.pop_front());
                void'(exp_store.pop_front());
                void'(exp_pcu.pop_front());
                void'(exp_dnpc.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/ex_unit_tb.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "ex_defs.svh"

module ex_unit_tb;
    import ex_pkg::*;

    localparam int ACCEPT_LIMIT = 200;
    localparam int DRAIN_LIMIT  = 500;

    logic                    clk = 1'b0;
    logic                    reset = 1'b1;
    logic                    flush = 1'b0;
    logic                    in_valid = 1'b0;
    logic                    in_ready;
    logic [`XLEN-1:0]        in_pc = '0;
    op_class_e               in_class = CLS_NONE;
    logic [2:0]              in_funct3 = '0;
    logic                    in_alt = 1'b0;
    logic [`REG_ADDR_W-1:0]  in_rd = '0;
    logic [`REG_ADDR_W-1:0]  in_rs1 = '0;
    logic [`REG_ADDR_W-1:0]  in_rs2 = '0;
    logic [`XLEN-1:0]        in_src_a = '0;
    logic [`XLEN-1:0]        in_src_b = '0;
    logic [`XLEN-1:0]        in_imm = '0;
    logic                    mem_wr_en = 1'b0;
    logic [`REG_ADDR_W-1:0]  mem_rd = '0;
    logic [`XLEN-1:0]        mem_data = '0;
    logic                    wb_wr_en = 1'b0;
    logic [`REG_ADDR_W-1:0]  wb_rd = '0;
    logic [`XLEN-1:0]        wb_data = '0;
    logic                    out_valid;
    logic                    out_ready = 1'b0;
    logic [`XLEN-1:0]        out_pc;
    op_class_e               out_class;
    logic [`REG_ADDR_W-1:0]  out_rd;
    logic [`XLEN-1:0]        out_result;
    logic [`XLEN-1:0]        out_store_data;
    logic                    pc_update;
    logic [`XLEN-1:0]        dnpc;
    int                      error_count;
    int                      pending;

    ex_unit ex_unit_i (.*);

    ex_unit_checker ex_unit_checker (
        .clk(clk), .reset(reset), .flush(flush), .out_valid(out_valid),
        .out_ready(out_ready), .pc_update(pc_update), .out_pc(out_pc),
        .out_class(out_class), .out_rd(out_rd), .out_result(out_result),
        .out_store_data(out_store_data), .dnpc(dnpc),
        .error_count(error_count), .pending(pending)
    );

    always #5 clk = ~clk;

    // MEM side stalls about one cycle in four
    initial begin
        void'($urandom(32'hce9f));
        forever begin
            @(posedge clk);
            out_ready <= ($urandom % 4) != 0;
        end
    end

    // in_ready seen right after the edge is the value the DUT sampled
    task automatic wait_accept(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < ACCEPT_LIMIT) begin
            @(posedge clk);
            ok = in_ready;
            cycles++;
        end
    endtask

    initial begin
        int          fd;
        int          cycles;
        int          line_no;
        bit          ok;
        bit          failed;
        string       text;
        logic [63:0] v[0:19];
        failed = 1'b0;
        line_no = 0;
        fd = $fopen("tests/ex_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            failed = 1'b1;
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        while (fd != 0 && !failed && !$feof(fd)) begin
            line_no++;
            if ($fgets(text, fd) > 0 && $sscanf(text,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18],
                v[19]) == 20) begin
                // present the item, then wait for the slot to open
                in_valid  <= 1'b1;
                in_class  <= op_class_e'(v[0][3:0]);
                in_funct3 <= v[1][2:0];
                in_alt    <= v[2][0];
                in_pc     <= v[4];
                in_imm    <= v[5];
                in_src_a  <= v[6];
                in_src_b  <= v[7];
                in_rs1    <= v[8][4:0];
                in_rs2    <= v[9][4:0];
                // rd tags the item with its line for the order check
                in_rd     <= line_no[4:0];
                wait_accept(ok);
                if (!ok) begin
                    $display("timeout waiting for in_ready at line %0d", line_no);
                    failed = 1'b1;
                end else begin
                    // bypass state belongs to the item now held
                    mem_wr_en <= v[10][0];
                    mem_rd    <= v[11][4:0];
                    mem_data  <= v[12];
                    wb_wr_en  <= v[13][0];
                    wb_rd     <= v[14][4:0];
                    wb_data   <= v[15];
                    if (v[3][0]) begin
                        // kill the held item, no new item during the flush cycle
                        flush    <= 1'b1;
                        in_valid <= 1'b0;
                        @(posedge clk);
                        flush <= 1'b0;
                    end
                end
            end
        end
        in_valid <= 1'b0;
        // drain whatever is still held
        cycles = 0;
        while (!failed && pending != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (pending != 0) begin
            $display("timeout, %0d items never reached the outputs", pending);
            failed = 1'b1;
        end
        $display("errors: %0d", error_count);
        if (failed || error_count != 0) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/ex_stimulus.txt ====
# hex: class funct3 alt flush pc imm src_a src_b rs1 rs2 mem_we mem_rd mem_data wb_we wb_rd
#      wb_data | result store_data pc_update dnpc (dnpc only checked when pc_update is 1)
9 0 0 0 1000 0 5 3 1 2 0 0 0 0 0 0 8 3 0 0
9 0 1 0 1000 0 5 7 1 2 0 0 0 0 0 0 fffffffffffffffe 7 0 0
9 2 0 0 1000 0 ffffffffffffffff 1 1 2 0 0 0 0 0 0 1 1 0 0
9 3 0 0 1000 0 ffffffffffffffff 1 1 2 0 0 0 0 0 0 0 1 0 0
9 7 0 0 1000 0 f0f0 ff00 1 2 0 0 0 0 0 0 f000 ff00 0 0
9 6 0 0 1000 0 f0 f 1 2 0 0 0 0 0 0 ff f 0 0
9 4 0 0 1000 0 ff f 1 2 0 0 0 0 0 0 f0 f 0 0
9 1 0 0 1000 0 1 3f 1 2 0 0 0 0 0 0 8000000000000000 3f 0 0
9 5 0 0 1000 0 8000000000000000 4 1 2 0 0 0 0 0 0 0800000000000000 4 0 0
9 5 1 0 1000 0 8000000000000000 4 1 2 0 0 0 0 0 0 f800000000000000 4 0 0
8 0 1 0 1000 400 10 99 1 2 1 2 dead 0 0 0 410 99 0 0
8 5 1 0 1000 404 ffffffffffffff00 0 1 2 0 0 0 0 0 0 fffffffffffffff0 0 0 0
1 0 0 0 1000 12345000 0 0 1 2 0 0 0 0 0 0 12345000 0 0 0
2 0 0 0 1000 2000 0 0 1 2 0 0 0 0 0 0 3000 0 0 0
3 0 0 0 1000 7f0 0 0 1 2 0 0 0 0 0 0 1004 0 0 0
9 0 0 1 1000 0 1 1 1 2 0 0 0 0 0 0 2 1 0 0
4 0 0 0 1000 10 2001 0 1 2 0 0 0 0 0 0 1004 0 1 2010
b 0 0 0 1000 0 7fffffff 1 1 2 0 0 0 0 0 0 ffffffff80000000 1 0 0
b 0 1 0 1000 0 0 1 1 2 0 0 0 0 0 0 ffffffffffffffff 1 0 0
a 1 0 0 1000 3f 1 0 1 2 0 0 0 0 0 0 ffffffff80000000 0 0 0
b 5 1 0 1000 0 180000000 24 1 2 0 0 0 0 0 0 fffffffff8000000 24 0 0
b 5 0 0 1000 0 80000000 4 1 2 0 0 0 0 0 0 8000000 4 0 0
9 0 0 0 1000 0 1 2 1 2 1 1 100 1 1 200 102 2 0 0
9 0 0 0 1000 0 3 3 3 3 0 3 999 1 3 50 a0 50 0 0
9 0 0 0 1000 0 0 0 0 0 1 0 77 1 0 88 0 0 0 0
7 0 0 0 1000 8 100 2 1 2 0 0 0 1 2 beef 108 beef 0 0
5 0 0 0 1000 40 5 5 1 2 0 0 0 0 0 0 a 5 1 1040
5 0 0 0 1000 fffffffffffffff0 5 5 1 2 0 0 0 0 0 0 a 5 0 0
5 1 0 0 1000 fffffffffffffff0 5 5 1 2 0 0 0 0 0 0 a 5 1 1004
5 1 0 0 1000 40 5 6 1 2 0 0 0 0 0 0 b 6 1 1040
5 4 0 0 1000 40 ffffffffffffffff 1 1 2 0 0 0 0 0 0 0 1 1 1040
5 4 0 0 1000 fffffffffffffff0 1 ffffffffffffffff 1 2 0 0 0 0 0 0 0 ffffffffffffffff 1 1004
5 5 0 0 1000 fffffffffffffff0 ffffffffffffffff 1 1 2 0 0 0 0 0 0 0 1 1 1004
5 5 0 0 1000 40 1 ffffffffffffffff 1 2 0 0 0 0 0 0 0 ffffffffffffffff 1 1040
5 6 0 0 1000 40 ffffffffffffffff 1 1 2 0 0 0 0 0 0 0 1 0 0
5 6 0 0 1000 fffffffffffffff0 1 ffffffffffffffff 1 2 0 0 0 0 0 0 0 ffffffffffffffff 0 0
5 7 0 0 1000 fffffffffffffff0 ffffffffffffffff 1 1 2 0 0 0 0 0 0 0 1 0 0
5 7 0 0 1000 40 1 ffffffffffffffff 1 2 0 0 0 0 0 0 0 ffffffffffffffff 0 0

// ==== tb.f ====
+incdir+include
verilog/ex_pkg.sv
verilog/ex_issue_reg.sv
verilog/ex_operand_fwd.sv
verilog/ex_alu.sv
verilog/ex_branch_unit.sv
verilog/ex_unit.sv
tests/ex_unit_checker.sv
tests/ex_unit_tb.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert
TOP      ?= ex_unit_tb
FILELIST ?= tb.f

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
